// File: Makefile
# Verilator build and run for the AFU CSR testbench

TOOL   = verilator
FLAGS  = --binary --timing --assert -Wno-fatal
TOP    = tb_afu_csr
FLIST  = flist.f
OBJDIR = obj_dir
LOG    = sim.log
PASS   = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS)" $(LOG) || (echo "Simulation did not pass"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: flist.f
src/afu_csr_pkg.sv
src/mmio_decode.sv
src/xlate_fail_monitor.sv
src/csr_read_mux.sv
src/afu_csr_top.sv
tb/tb_afu_csr.sv

// File: src/afu_csr_pkg.sv
// AFU CSR package with the global register map, widths and the bus structs

package afu_csr_pkg;

    // ============================================================
    // Widths and constants
    // ============================================================

    // MMIO addresses arrive as qword indices
    localparam int MMIO_ADDR_WIDTH_DEF = 16;
    localparam int MMIO_TID_WIDTH = 9;

    // Sixteen global CSRs sit at the bottom of the MMIO space
    localparam int CSR_IDX_WIDTH = 4;

    localparam logic [CSR_IDX_WIDTH-1:0] CSR_TEST_ID_LO = 4'd0;
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_TEST_ID_HI = 4'd1;
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_CONFIG     = 4'd2;
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_RD_FAIL_VA = 4'd3;
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_WR_FAIL_VA = 4'd4;
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_FAIL_CNT   = 4'd5;
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_SCRATCH    = 4'd6;

    // Unique ID software uses to recognize this design
    localparam logic [127:0] TEST_ID = 128'h5a3e91c2_07d4_4b8f_a61e_3c9d72f0b845;

    localparam int FAIL_CNT_WIDTH = 16;

    // ============================================================
    // Bus structs
    // ============================================================

    // Host MMIO request, at most one of the two valids is set
    typedef struct packed {
        logic                           rd_valid;
        logic                           wr_valid;
        logic [MMIO_ADDR_WIDTH_DEF-1:0] addr;
        logic [MMIO_TID_WIDTH-1:0]      tid;
        logic [63:0]                    data;
    } mmio_req_t;

    // MMIO read response back to the host
    typedef struct packed {
        logic                      valid;
        logic [MMIO_TID_WIDTH-1:0] tid;
        logic [63:0]               data;
    } mmio_rsp_t;

    // Decoded CSR access
    typedef struct packed {
        logic                      rd;
        logic                      wr;
        logic [CSR_IDX_WIDTH-1:0]  idx;
        logic [MMIO_TID_WIDTH-1:0] tid;
        logic [63:0]               wr_data;
    } csr_cmd_t;

    // Host memory request after virtual to physical translation
    typedef struct packed {
        logic        valid;
        logic        error;
        logic [63:0] vaddr;
    } xlate_req_t;

    // Request forwarded to host memory
    typedef struct packed {
        logic        valid;
        logic [63:0] addr;
    } mem_req_t;

    // Failure statistics for one channel
    typedef struct packed {
        logic [63:0]               fail_va;
        logic [FAIL_CNT_WIDTH-1:0] fail_cnt;
    } fail_stat_t;

endpackage

// File: src/afu_csr_top.sv
// AFU CSR top level joining MMIO decode, the two failure monitors and the read-back mux
`timescale 1ns/10ps

module afu_csr_top
#(
    parameter int MMIO_ADDR_WIDTH = afu_csr_pkg::MMIO_ADDR_WIDTH_DEF,
    parameter int NUM_PORTS_G1    = 0
)
(
    input  logic                    clk,
    input  logic                    arst_n,

    // Host MMIO
    input  afu_csr_pkg::mmio_req_t  mmio_req,
    output afu_csr_pkg::mmio_rsp_t  mmio_rsp,

    // Translated requests in
    input  afu_csr_pkg::xlate_req_t rd_xlate,
    input  afu_csr_pkg::xlate_req_t wr_xlate,

    // Good requests out to host memory
    output afu_csr_pkg::mem_req_t   rd_mem,
    output afu_csr_pkg::mem_req_t   wr_mem
);

    import afu_csr_pkg::*;

    csr_cmd_t   csr_cmd;
    logic       clear_stats;
    fail_stat_t rd_stats;
    fail_stat_t wr_stats;

    // ============================================================
    // MMIO decode
    // ============================================================

    mmio_decode
    #(
        .MMIO_ADDR_WIDTH (MMIO_ADDR_WIDTH)
    )
    u_decode
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .mmio_req    (mmio_req),
        .csr_cmd     (csr_cmd),
        .clear_stats (clear_stats)
    );

    // ============================================================
    // Failure monitors
    // ============================================================

    // Read channel
    xlate_fail_monitor u_rd_mon
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear_stats (clear_stats),
        .xlate_in    (rd_xlate),
        .mem_out     (rd_mem),
        .stats       (rd_stats)
    );

    // Write channel, cleared together with the read channel
    xlate_fail_monitor u_wr_mon
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear_stats (clear_stats),
        .xlate_in    (wr_xlate),
        .mem_out     (wr_mem),
        .stats       (wr_stats)
    );

    // ============================================================
    // CSR read-back
    // ============================================================

    csr_read_mux
    #(
        .NUM_PORTS_G1 (NUM_PORTS_G1)
    )
    u_read_mux
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .csr_cmd  (csr_cmd),
        .rd_stats (rd_stats),
        .wr_stats (wr_stats),
        .mmio_rsp (mmio_rsp)
    );

endmodule

// File: src/csr_read_mux.sv
// CSR read-back block holding the scratch register and returning MMIO read data
`timescale 1ns/10ps

module csr_read_mux
#(
    parameter int NUM_PORTS_G1 = 0
)
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  afu_csr_pkg::csr_cmd_t   csr_cmd,
    input  afu_csr_pkg::fail_stat_t rd_stats,
    input  afu_csr_pkg::fail_stat_t wr_stats,
    output afu_csr_pkg::mmio_rsp_t  mmio_rsp
);

    import afu_csr_pkg::*;

    // The primary port always exists
    localparam int NUM_PORTS_G0 = 1;

    logic [63:0] scratch;
    logic [63:0] rd_word;

    // ============================================================
    // Scratch register
    // ============================================================

    // Software uses this to check that MMIO writes land
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scratch <= '0;
        end
        else if (csr_cmd.wr && (csr_cmd.idx == CSR_SCRATCH))
        begin
            scratch <= csr_cmd.wr_data;
        end
    end

    // ============================================================
    // Read select
    // ============================================================

    always_comb
    begin
        case (csr_cmd.idx)
            CSR_TEST_ID_LO: rd_word = TEST_ID[63:0];
            CSR_TEST_ID_HI: rd_word = TEST_ID[127:64];
            // Port counts tell software how many channel groups exist
            CSR_CONFIG:     rd_word = {48'd0, 8'(NUM_PORTS_G1), 8'(NUM_PORTS_G0)};
            CSR_RD_FAIL_VA: rd_word = rd_stats.fail_va;
            CSR_WR_FAIL_VA: rd_word = wr_stats.fail_va;
            // Read count low, write count high
            CSR_FAIL_CNT:   rd_word = {32'd0, wr_stats.fail_cnt, rd_stats.fail_cnt};
            CSR_SCRATCH:    rd_word = scratch;
            default:        rd_word = '0;
        endcase
    end

    // ============================================================
    // Response register
    // ============================================================

    // The tid rides along so the host can match the response
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mmio_rsp.valid <= 1'b0;
        end
        else
        begin
            mmio_rsp.valid <= csr_cmd.rd;
            mmio_rsp.tid   <= csr_cmd.tid;
            mmio_rsp.data  <= rd_word;
        end
    end

endmodule

// File: src/mmio_decode.sv
// MMIO decoder turning host register requests into CSR read, write and clear strobes
`timescale 1ns/10ps

module mmio_decode
#(
    parameter int MMIO_ADDR_WIDTH = afu_csr_pkg::MMIO_ADDR_WIDTH_DEF
)
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  afu_csr_pkg::mmio_req_t mmio_req,
    output afu_csr_pkg::csr_cmd_t  csr_cmd,
    output logic                   clear_stats
);

    import afu_csr_pkg::*;

    // Reads outside the window still answer, using an index that reads zero
    localparam logic [CSR_IDX_WIDTH-1:0] IDX_OUT_OF_RANGE = '1;

    logic                     in_window;
    logic [CSR_IDX_WIDTH-1:0] req_idx;

    // ============================================================
    // Address window check
    // ============================================================

    // The global window is the first 16 qwords, so every bit above the
    // index must be zero
    assign in_window = (mmio_req.addr[MMIO_ADDR_WIDTH-1:CSR_IDX_WIDTH] == '0);

    // Out-of-window reads get pointed at the unused top index
    assign req_idx = in_window ? mmio_req.addr[CSR_IDX_WIDTH-1:0] : IDX_OUT_OF_RANGE;

    // ============================================================
    // Registered command
    // ============================================================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            csr_cmd.rd  <= 1'b0;
            csr_cmd.wr  <= 1'b0;
            clear_stats <= 1'b0;
        end
        else
        begin
            // Every read gets a response so the host never waits on a tid
            csr_cmd.rd <= mmio_req.rd_valid;

            // Writes outside the window are simply dropped
            csr_cmd.wr <= mmio_req.wr_valid && in_window;

            // Any write to the counter CSR resets both channel counters
            clear_stats <= mmio_req.wr_valid && in_window &&
                           (req_idx == CSR_FAIL_CNT);

            csr_cmd.idx     <= req_idx;
            csr_cmd.tid     <= mmio_req.tid;
            csr_cmd.wr_data <= mmio_req.data;
        end
    end

endmodule

// File: src/xlate_fail_monitor.sv
// Translation failure monitor that forwards good requests and counts the failed ones
`timescale 1ns/10ps

module xlate_fail_monitor
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    clear_stats,
    input  afu_csr_pkg::xlate_req_t xlate_in,
    output afu_csr_pkg::mem_req_t   mem_out,
    output afu_csr_pkg::fail_stat_t stats
);

    import afu_csr_pkg::*;

    // Counter saturates here instead of wrapping
    localparam logic [FAIL_CNT_WIDTH-1:0] CNT_MAX = '1;

    logic xlate_ok;
    logic xlate_fail;

    assign xlate_ok   = xlate_in.valid && !xlate_in.error;
    assign xlate_fail = xlate_in.valid && xlate_in.error;

    // ============================================================
    // Forward path
    // ============================================================

    // Successful translations go out one cycle later with the same address
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_out.valid <= 1'b0;
        end
        else
        begin
            mem_out.valid <= xlate_ok;
            mem_out.addr  <= xlate_in.vaddr;
        end
    end

    // ============================================================
    // Failure statistics
    // ============================================================

    // Failed requests are sunk here and never reach host memory.
    // Only the newest failed address is kept
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            stats <= '0;
        end
        else
        begin
            if (xlate_fail)
            begin
                stats.fail_va <= xlate_in.vaddr;
            end

            // A clear in the same cycle as a failure leaves the count at zero
            if (clear_stats)
            begin
                stats.fail_cnt <= '0;
            end
            else if (xlate_fail && (stats.fail_cnt != CNT_MAX))
            begin
                stats.fail_cnt <= stats.fail_cnt + 1'b1;
            end
        end
    end

endmodule

// File: tb/tb_afu_csr.sv
// Testbench for the AFU CSR block covering MMIO reads, request forwarding and failure statistics
`timescale 1ns/10ps

module tb_afu_csr;

    import afu_csr_pkg::*;

    localparam int NUM_PORTS_G1   = 2;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RSP_WAIT_MAX   = 8;

    logic       clk;
    logic       arst_n;
    mmio_req_t  mmio_req;
    mmio_rsp_t  mmio_rsp;
    xlate_req_t rd_xlate;
    xlate_req_t wr_xlate;
    mem_req_t   rd_mem;
    mem_req_t   wr_mem;

    // Expected response, driven together with each read request
    mmio_rsp_t  exp_rsp;
    mmio_rsp_t  exp_rsp_q1;
    mmio_rsp_t  exp_rsp_q2;

    // Expected forwarding, set by the sender in the cycle a request is driven
    mem_req_t   exp_rd_fwd;
    mem_req_t   exp_wr_fwd;
    mem_req_t   exp_rd_mem;
    mem_req_t   exp_wr_mem;

    // Reference model of the statistics and the scratch register
    logic [63:0]               model_rd_va;
    logic [63:0]               model_wr_va;
    logic [FAIL_CNT_WIDTH-1:0] model_rd_cnt;
    logic [FAIL_CNT_WIDTH-1:0] model_wr_cnt;
    logic [63:0]               model_scratch;

    integer                    seed;
    int                        err_count;
    int                        test_err_start;
    int                        tests_passed;
    int                        tests_with_errors;
    int                        cycle_count;
    int                        i;
    logic [MMIO_TID_WIDTH-1:0] next_tid;
    logic [63:0]               wdata;
    string                     test_name;

    afu_csr_top
    #(
        .NUM_PORTS_G1 (NUM_PORTS_G1)
    )
    u_dut
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .mmio_req (mmio_req),
        .mmio_rsp (mmio_rsp),
        .rd_xlate (rd_xlate),
        .wr_xlate (wr_xlate),
        .rd_mem   (rd_mem),
        .wr_mem   (wr_mem)
    );

    always
    begin
        #5 clk = ~clk;
    end

    // ============================================================
    // Expected timing and checks
    // ============================================================

    // Read responses trail the request by two edges, forwarded requests by one
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            exp_rsp_q1 <= '0;
            exp_rsp_q2 <= '0;
            exp_rd_mem <= '0;
            exp_wr_mem <= '0;
        end
        else
        begin
            exp_rsp_q1 <= exp_rsp;
            exp_rsp_q2 <= exp_rsp_q1;
            exp_rd_mem <= exp_rd_fwd;
            exp_wr_mem <= exp_wr_fwd;
        end
    end

    // Valid, tid and data of every MMIO read response
    assert property (@(posedge clk) disable iff (!arst_n)
        mmio_rsp.valid == exp_rsp_q2.valid &&
        (!exp_rsp_q2.valid || (mmio_rsp.tid == exp_rsp_q2.tid &&
                               mmio_rsp.data == exp_rsp_q2.data)))
    else
    begin
        err_count++;
        $display("[FAIL] %s: mmio_rsp expected %h actual %h",
                 test_name, $sampled(exp_rsp_q2), $sampled(mmio_rsp));
    end

    // Read channel forwarding
    assert property (@(posedge clk) disable iff (!arst_n)
        rd_mem.valid == exp_rd_mem.valid &&
        (!exp_rd_mem.valid || rd_mem.addr == exp_rd_mem.addr))
    else
    begin
        err_count++;
        $display("[FAIL] %s: rd_mem expected %h actual %h",
                 test_name, $sampled(exp_rd_mem), $sampled(rd_mem));
    end

    // Write channel forwarding
    assert property (@(posedge clk) disable iff (!arst_n)
        wr_mem.valid == exp_wr_mem.valid &&
        (!exp_wr_mem.valid || wr_mem.addr == exp_wr_mem.addr))
    else
    begin
        err_count++;
        $display("[FAIL] %s: wr_mem expected %h actual %h",
                 test_name, $sampled(exp_wr_mem), $sampled(wr_mem));
    end

    // Hard stop in case a wait never ends
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout reached after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ============================================================
    // Helpers
    // ============================================================

    // Inputs always change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = err_count;
    endtask

    task automatic close_test();
        int errs;
        errs = err_count - test_err_start;
        if (errs == 0)
        begin
            tests_passed++;
            $display("%s: passed", test_name);
        end
        else
        begin
            tests_with_errors++;
            $display("%s: %0d check errors", test_name, errs);
        end
    endtask

    // Register map as software sees it
    function automatic logic [63:0] expected_csr(input logic [15:0] addr);
        logic [63:0] word;
        word = '0;
        // Only the first 16 qwords are mapped
        if (addr[15:4] == '0)
        begin
            case (addr[3:0])
                4'd0:    word = TEST_ID[63:0];
                4'd1:    word = TEST_ID[127:64];
                4'd2:    word = {48'd0, 8'(NUM_PORTS_G1), 8'd1};
                4'd3:    word = model_rd_va;
                4'd4:    word = model_wr_va;
                4'd5:    word = {32'd0, model_wr_cnt, model_rd_cnt};
                4'd6:    word = model_scratch;
                default: word = '0;
            endcase
        end
        return word;
    endfunction

    task automatic mmio_read(input logic [15:0] addr);
        int waited;
        mmio_req.rd_valid = 1'b1;
        mmio_req.addr     = addr;
        mmio_req.tid      = next_tid;
        exp_rsp.valid     = 1'b1;
        exp_rsp.tid       = next_tid;
        exp_rsp.data      = expected_csr(addr);
        next_tid          = next_tid + 9'd1;
        step();
        mmio_req.rd_valid = 1'b0;
        exp_rsp.valid     = 1'b0;
        waited = 0;
        while (!mmio_rsp.valid && waited < RSP_WAIT_MAX)
        begin
            step();
            waited++;
        end
        if (!mmio_rsp.valid)
        begin
            err_count++;
            $display("%s: read of address %h got no MMIO response", test_name, addr);
        end
        // The response check runs on the next edge
        step();
    endtask

    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        mmio_req.wr_valid = 1'b1;
        mmio_req.addr     = addr;
        mmio_req.data     = data;
        if (addr == 16'd6)
        begin
            model_scratch = data;
        end
        if (addr == 16'd5)
        begin
            model_rd_cnt = '0;
            model_wr_cnt = '0;
        end
        step();
        mmio_req.wr_valid = 1'b0;
    endtask

    // One translated request on the read channel or the write channel
    task automatic xlate_send(input logic to_wr, input logic [63:0] vaddr, input logic err);
        if (to_wr)
        begin
            wr_xlate = {1'b1, err, vaddr};
            // Only a request sent without an error is expected at the output
            exp_wr_fwd.valid = !err;
            exp_wr_fwd.addr  = vaddr;
            if (err)
            begin
                model_wr_va = vaddr;
                if (model_wr_cnt != '1)
                begin
                    model_wr_cnt++;
                end
            end
        end
        else
        begin
            rd_xlate = {1'b1, err, vaddr};
            exp_rd_fwd.valid = !err;
            exp_rd_fwd.addr  = vaddr;
            if (err)
            begin
                model_rd_va = vaddr;
                if (model_rd_cnt != '1)
                begin
                    model_rd_cnt++;
                end
            end
        end
        step();
        rd_xlate.valid = 1'b0;
        wr_xlate.valid = 1'b0;
        exp_rd_fwd     = '0;
        exp_wr_fwd     = '0;
    endtask

    task automatic random_traffic(input int count);
        int          n;
        logic [63:0] va;
        logic        err;
        for (n = 0; n < count; n++)
        begin
            va  = {$random(seed), $random(seed)};
            // About one request in four fails translation
            err = (($random(seed) & 3) == 0);
            xlate_send(n[0], va, err);
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================

    initial
    begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        mmio_req      = '0;
        rd_xlate      = '0;
        wr_xlate      = '0;
        exp_rsp       = '0;
        exp_rd_fwd    = '0;
        exp_wr_fwd    = '0;
        model_rd_va   = '0;
        model_wr_va   = '0;
        model_rd_cnt  = '0;
        model_wr_cnt  = '0;
        model_scratch = '0;
        seed          = 32'h28bf;
        next_tid      = '0;
        test_name     = "reset";
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        step();

        start_test("test_id");
        mmio_read(16'd0);
        mmio_read(16'd1);
        close_test();

        start_test("config_and_unmapped");
        mmio_read(16'd2);
        for (i = 7; i < 16; i++)
        begin
            mmio_read(16'(i));
        end
        mmio_read(16'h0010);
        mmio_read(16'h8006);
        mmio_read(16'($random(seed)) | 16'h0100);
        close_test();

        start_test("forwarding");
        random_traffic(80);
        step();
        close_test();

        start_test("fail_stats");
        random_traffic(40);
        mmio_read(16'd3);
        mmio_read(16'd4);
        mmio_read(16'd5);
        close_test();

        start_test("scratch_and_clear");
        wdata = {$random(seed), $random(seed)};
        mmio_write(16'd6, wdata);
        mmio_read(16'd6);
        mmio_write(16'd5, 64'd0);
        step();
        mmio_read(16'd5);
        random_traffic(12);
        mmio_read(16'd5);
        // Failures on both channels in the cycle the clear reaches the monitors
        mmio_write(16'd5, 64'd0);
        rd_xlate    = {1'b1, 1'b1, {$random(seed), $random(seed)}};
        wr_xlate    = {1'b1, 1'b1, {$random(seed), $random(seed)}};
        model_rd_va = rd_xlate.vaddr;
        model_wr_va = wr_xlate.vaddr;
        step();
        rd_xlate.valid = 1'b0;
        wr_xlate.valid = 1'b0;
        mmio_read(16'd5);
        mmio_read(16'd3);
        mmio_read(16'd4);
        close_test();

        $display("Tests passed: %0d, tests with errors: %0d, check errors: %0d",
                 tests_passed, tests_with_errors, err_count);
        if (err_count == 0 && tests_with_errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
